// ==== verilog/fp_mul_pkg.sv ====
// Widths, constants, rounding modes, flag and side-band types for the FMUL.S pipeline
package fp_mul_pkg;

  // ==================================================
  // Format widths
  // ==================================================

  localparam int unsigned FpWidth    = 32;
  localparam int unsigned ExpBits    = 8;
  localparam int unsigned FracBits   = 23;
  // Significand including the hidden bit
  localparam int unsigned MantBits   = FracBits + 1;
  localparam int unsigned ProdBits   = 2 * MantBits;
  // Signed working exponent, wide enough for underflow and overflow excursions
  localparam int unsigned ExpExtBits = ExpBits + 2;
  localparam int signed   ExpBias    = 127;
  localparam int unsigned LzcBits    = 6;

  // Depth of the delay line behind the mantissa multiplier
  localparam int unsigned MulPipeStages = 2;

  // Mantissa plus guard and round bits, the unit of the subnormal shift
  localparam int unsigned RndVecBits = MantBits + 2;

  // ==================================================
  // Encodings
  // ==================================================

  localparam logic [ExpBits-1:0] ExpAllOnes   = {ExpBits{1'b1}};
  localparam logic [FpWidth-1:0] CanonicalNan = 32'h7FC0_0000;

  // Rounding mode, as in the RISC-V frm field
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } rm_e;

  // Exception flags, divide-by-zero never arises in a multiply
  typedef struct packed {
    logic nv;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

  // Everything that travels alongside the datapath of one operation
  typedef struct packed {
    logic                         sign;
    logic signed [ExpExtBits-1:0] exp;
    rm_e                          rm;
    logic                         is_special;
    logic        [FpWidth-1:0]    special_result;
    logic                         special_invalid;
  } fp_side_t;

  // Both significands fed to the multiplier
  typedef struct packed {
    logic [MantBits-1:0] a;
    logic [MantBits-1:0] b;
  } mant_pair_t;

endpackage

// ==== verilog/fp_stage_if.sv ====
// Stage-to-stage link: load strobe, side-band, typed payload and zero marker
interface fp_stage_if #(
  parameter type payload_t = logic
) ();

  // High for one cycle when side, payload and zero hold a new operation
  logic                 ld;
  fp_mul_pkg::fp_side_t side;
  payload_t             payload;
  // Product of this operation is zero
  logic                 zero;

  // Producing stage
  modport src (
    output ld,
    output side,
    output payload,
    output zero
  );

  // Consuming stage, samples on the edge where ld is high
  modport dst (
    input ld,
    input side,
    input payload,
    input zero
  );

endinterface

// ==== verilog/fp_operand_unpack.sv ====
// Field extraction and zero/Inf/NaN/sNaN classification of one binary32 operand
module fp_operand_unpack
  import fp_mul_pkg::*;
(
  input  logic [FpWidth-1:0]  i_operand,
  output logic                o_sign,
  output logic [ExpBits-1:0]  o_exp_adj,
  output logic [MantBits-1:0] o_mant,
  output logic                o_is_zero,
  output logic                o_is_inf,
  output logic                o_is_nan,
  output logic                o_is_snan
);

  logic [ExpBits-1:0]  exp_field;
  logic [FracBits-1:0] frac_field;
  logic                exp_zero;
  logic                exp_ones;
  logic                frac_zero;

  assign o_sign     = i_operand[FpWidth-1];
  assign exp_field  = i_operand[FpWidth-2 -: ExpBits];
  assign frac_field = i_operand[FracBits-1:0];

  assign exp_zero  = (exp_field == '0);
  assign exp_ones  = (exp_field == ExpAllOnes);
  assign frac_zero = (frac_field == '0);

  // Subnormals have no hidden bit but share the exponent of the smallest normal
  assign o_exp_adj = exp_zero ? ExpBits'(1) : exp_field;
  assign o_mant    = {~exp_zero, frac_field};

  assign o_is_zero = exp_zero & frac_zero;
  assign o_is_inf  = exp_ones & frac_zero;
  assign o_is_nan  = exp_ones & ~frac_zero;
  // Quiet bit clear marks a signalling NaN
  assign o_is_snan = o_is_nan & ~frac_field[FracBits-1];

endmodule

// ==== verilog/fp_mul_front.sv ====
// Operand capture, unpacking, sign and exponent, special-case resolution
module fp_mul_front
  import fp_mul_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_valid,
  input  logic [FpWidth-1:0] i_operand_a,
  input  logic [FpWidth-1:0] i_operand_b,
  input  rm_e                i_rounding_mode,
  fp_stage_if.src            o_mul
);

  // ==================================================
  // Input register
  // ==================================================

  logic               valid_q;
  logic [FpWidth-1:0] op_a_q;
  logic [FpWidth-1:0] op_b_q;
  rm_e                rm_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      op_a_q <= i_operand_a;
      op_b_q <= i_operand_b;
      rm_q   <= i_rounding_mode;
    end
  end

  // ==================================================
  // Unpack and classify
  // ==================================================

  logic                sign_a, sign_b;
  logic [ExpBits-1:0]  exp_a, exp_b;
  logic [MantBits-1:0] mant_a, mant_b;
  logic                zero_a, zero_b;
  logic                inf_a, inf_b;
  logic                nan_a, nan_b;
  logic                snan_a, snan_b;

  fp_operand_unpack u_unpack_a (
    .i_operand (op_a_q),
    .o_sign    (sign_a),
    .o_exp_adj (exp_a),
    .o_mant    (mant_a),
    .o_is_zero (zero_a),
    .o_is_inf  (inf_a),
    .o_is_nan  (nan_a),
    .o_is_snan (snan_a)
  );

  fp_operand_unpack u_unpack_b (
    .i_operand (op_b_q),
    .o_sign    (sign_b),
    .o_exp_adj (exp_b),
    .o_mant    (mant_b),
    .o_is_zero (zero_b),
    .o_is_inf  (inf_b),
    .o_is_nan  (nan_b),
    .o_is_snan (snan_b)
  );

  fp_side_t side_d;

  // Special cases in priority order: NaN, Inf x 0, Inf, zero
  always_comb begin
    side_d                 = '0;
    side_d.sign            = sign_a ^ sign_b;
    side_d.rm              = rm_q;
    // Tentative exponent, normalization corrects it later
    side_d.exp             = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
                             - $signed(ExpExtBits'(ExpBias));
    if (nan_a || nan_b) begin
      side_d.is_special      = 1'b1;
      side_d.special_result  = CanonicalNan;
      // Quiet NaNs pass silently
      side_d.special_invalid = snan_a | snan_b;
    end else if ((inf_a && zero_b) || (zero_a && inf_b)) begin
      side_d.is_special      = 1'b1;
      side_d.special_result  = CanonicalNan;
      side_d.special_invalid = 1'b1;
    end else if (inf_a || inf_b) begin
      side_d.is_special      = 1'b1;
      side_d.special_result  = {side_d.sign, ExpAllOnes, {FracBits{1'b0}}};
    end else if (zero_a || zero_b) begin
      side_d.is_special      = 1'b1;
      side_d.special_result  = {side_d.sign, {(FpWidth-1){1'b0}}};
    end
  end

  // ==================================================
  // Unpack register, drives mul_if
  // ==================================================

  logic       ld_q;
  fp_side_t   side_q;
  mant_pair_t pair_q;
  logic       zero_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ld_q <= 1'b0;
    end else begin
      ld_q <= valid_q;
    end
  end

  always_ff @(posedge i_clk) begin
    side_q   <= side_d;
    pair_q.a <= mant_a;
    pair_q.b <= mant_b;
    // A zero significand forces a zero product
    zero_q   <= zero_a | zero_b;
  end

  assign o_mul.ld      = ld_q;
  assign o_mul.side    = side_q;
  assign o_mul.payload = pair_q;
  assign o_mul.zero    = zero_q;

  a_mul_ld_known: assert property (@(posedge i_clk) disable iff (i_rst)
    !$isunknown(o_mul.ld));

endmodule

// ==== verilog/fp_mant_mul.sv ====
// 24x24 significand multiplier with a short product delay line
module fp_mant_mul
  import fp_mul_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst,
  fp_stage_if.dst i_mul,
  fp_stage_if.src o_norm
);

  // ==================================================
  // Product register
  // ==================================================

  logic                ld_q;
  logic [ProdBits-1:0] prod_q;
  fp_side_t            side_q;
  logic                zero_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ld_q <= 1'b0;
    end else begin
      ld_q <= i_mul.ld;
    end
  end

  always_ff @(posedge i_clk) begin
    prod_q <= i_mul.payload.a * i_mul.payload.b;
    side_q <= i_mul.side;
    // Product is zero exactly when one significand is zero
    zero_q <= i_mul.zero;
  end

  // ==================================================
  // Delay line
  // ==================================================

  logic [ProdBits-1:0]      prod_pipe [MulPipeStages];
  fp_side_t                 side_pipe [MulPipeStages];
  logic [MulPipeStages-1:0] zero_pipe;
  logic [MulPipeStages-1:0] ld_pipe;

  // Strobe shifts alongside the data
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ld_pipe <= '0;
    end else begin
      ld_pipe <= {ld_pipe[MulPipeStages-2:0], ld_q};
    end
  end

  always_ff @(posedge i_clk) begin
    prod_pipe[0] <= prod_q;
    side_pipe[0] <= side_q;
    zero_pipe[0] <= zero_q;
    for (int i = 1; i < MulPipeStages; i++) begin
      prod_pipe[i] <= prod_pipe[i-1];
      side_pipe[i] <= side_pipe[i-1];
      zero_pipe[i] <= zero_pipe[i-1];
    end
  end

  assign o_norm.ld      = ld_pipe[MulPipeStages-1];
  assign o_norm.payload = prod_pipe[MulPipeStages-1];
  assign o_norm.side    = side_pipe[MulPipeStages-1];
  assign o_norm.zero    = zero_pipe[MulPipeStages-1];

endmodule

// ==== verilog/fp_normalize.sv ====
// Leading-zero count and normalizing shift of the raw product, two stages
module fp_normalize
  import fp_mul_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst,
  fp_stage_if.dst i_norm,
  fp_stage_if.src o_rnd
);

  // Zeros above the highest set bit, all-zero input gives the full width
  function automatic logic [LzcBits-1:0] count_lz(input logic [ProdBits-2:0] value);
    logic [LzcBits-1:0] count;
    count = LzcBits'(ProdBits - 1);
    // Scanning upward, so the highest one wins
    for (int i = 0; i < ProdBits - 1; i++) begin
      if (value[i]) begin
        count = LzcBits'(ProdBits - 2 - i);
      end
    end
    return count;
  endfunction

  // ==================================================
  // Stage 1: count leading zeros
  // ==================================================

  logic                ld_1;
  logic [ProdBits-1:0] prod_1;
  fp_side_t            side_1;
  logic                zero_1;
  logic                msb_1;
  logic [LzcBits-1:0]  lzc_1;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ld_1 <= 1'b0;
    end else begin
      ld_1 <= i_norm.ld;
    end
  end

  always_ff @(posedge i_clk) begin
    prod_1 <= i_norm.payload;
    side_1 <= i_norm.side;
    zero_1 <= i_norm.zero;
    // Product of two [1,2) values can reach [2,4), bit 47 checked on its own
    msb_1  <= i_norm.payload[ProdBits-1];
    lzc_1  <= count_lz(i_norm.payload[ProdBits-2:0]);
  end

  // ==================================================
  // Stage 2: shift the leading one to bit 47
  // ==================================================

  logic [ProdBits-1:0] prod_n;
  fp_side_t            side_n;

  always_comb begin
    side_n = side_1;
    if (zero_1) begin
      prod_n     = '0;
      side_n.exp = '0;
    end else if (msb_1) begin
      prod_n     = prod_1;
      side_n.exp = side_1.exp + 1;
    end else begin
      // One extra place moves bit 46 up to the MSB
      prod_n     = prod_1 << (lzc_1 + 1'b1);
      side_n.exp = side_1.exp - $signed(ExpExtBits'(lzc_1));
    end
  end

  logic                ld_2;
  logic [ProdBits-1:0] prod_2;
  fp_side_t            side_2;
  logic                zero_2;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ld_2 <= 1'b0;
    end else begin
      ld_2 <= ld_1;
    end
  end

  always_ff @(posedge i_clk) begin
    prod_2 <= prod_n;
    side_2 <= side_n;
    zero_2 <= zero_1;
  end

  assign o_rnd.ld      = ld_2;
  assign o_rnd.payload = prod_2;
  assign o_rnd.side    = side_2;
  assign o_rnd.zero    = zero_2;

  // Zero marker comes from the front end, the leading one from this shift
  a_norm_lead_one: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_rnd.ld && !o_rnd.zero && !o_rnd.side.is_special) |-> o_rnd.payload[ProdBits-1]);

endmodule

// ==== verilog/fp_round_pack.sv ====
// Subnormal shift, rounding, result packing and exception flags
module fp_round_pack
  import fp_mul_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_rst,
  fp_stage_if.dst            i_rnd,
  output logic               o_valid,
  output logic [FpWidth-1:0] o_result,
  output fp_flags_t          o_flags
);

  // ==================================================
  // Stage A: guard/round/sticky and subnormal shift
  // ==================================================

  logic signed [ExpExtBits-1:0] sub_amt;
  logic                         is_sub;
  logic [LzcBits-1:0]           sub_shift;
  logic [2*RndVecBits-1:0]      grs_vec;
  logic                         sticky_in;
  fp_side_t                     side_s;

  // Right shift needed to bring the exponent up to the subnormal level
  assign sub_amt   = 1 - i_rnd.side.exp;
  assign is_sub    = (i_rnd.side.exp <= 0);
  // Beyond the full vector width every bit lands in sticky anyway
  assign sub_shift = !is_sub                ? '0 :
                     (sub_amt > RndVecBits) ? LzcBits'(RndVecBits) :
                                              LzcBits'(sub_amt);

  // Mantissa, guard and round on top with the shifted-out bits collecting below
  assign grs_vec   = {i_rnd.payload[ProdBits-1 -: RndVecBits], {RndVecBits{1'b0}}} >> sub_shift;
  assign sticky_in = |i_rnd.payload[ProdBits-RndVecBits-1:0];

  always_comb begin
    side_s = i_rnd.side;
    if (is_sub) begin
      side_s.exp = '0;
    end
  end

  logic                ld_a;
  fp_side_t            side_a;
  logic                zero_a;
  logic [MantBits-1:0] mant_a;
  logic                guard_a;
  logic                round_a;
  logic                sticky_a;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ld_a <= 1'b0;
    end else begin
      ld_a <= i_rnd.ld;
    end
  end

  always_ff @(posedge i_clk) begin
    side_a   <= side_s;
    zero_a   <= i_rnd.zero;
    mant_a   <= grs_vec[2*RndVecBits-1 -: MantBits];
    guard_a  <= grs_vec[RndVecBits+1];
    round_a  <= grs_vec[RndVecBits];
    sticky_a <= sticky_in | (|grs_vec[RndVecBits-1:0]);
  end

  // ==================================================
  // Stage B: round-up decision
  // ==================================================

  logic lost_a;
  logic round_up_d;

  assign lost_a = guard_a | round_a | sticky_a;

  always_comb begin
    case (side_a.rm)
      // Ties go to the even neighbour
      RNE:     round_up_d = guard_a & (round_a | sticky_a | mant_a[0]);
      RTZ:     round_up_d = 1'b0;
      RDN:     round_up_d = side_a.sign & lost_a;
      RUP:     round_up_d = ~side_a.sign & lost_a;
      RMM:     round_up_d = guard_a;
      default: round_up_d = 1'b0;
    endcase
  end

  logic                ld_b;
  fp_side_t            side_b;
  logic                zero_b;
  logic [MantBits-1:0] mant_b;
  logic                round_up_b;
  logic                inexact_b;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ld_b <= 1'b0;
    end else begin
      ld_b <= ld_a;
    end
  end

  always_ff @(posedge i_clk) begin
    side_b     <= side_a;
    zero_b     <= zero_a;
    mant_b     <= mant_a;
    round_up_b <= round_up_d;
    inexact_b  <= lost_a;
  end

  // ==================================================
  // Stage C: increment, pack, flags
  // ==================================================

  logic [MantBits:0]            mant_sum;
  logic [MantBits-1:0]          mant_rnd;
  logic signed [ExpExtBits-1:0] exp_rnd;
  logic [ExpBits-1:0]           exp_field;
  logic                         overflow;
  logic                         to_max;
  logic [FpWidth-1:0]           result_d;
  fp_flags_t                    flags_d;

  always_comb begin
    mant_sum = {1'b0, mant_b} + (MantBits+1)'(round_up_b);
    // Carry out of the mantissa bumps the exponent
    if (mant_sum[MantBits]) begin
      mant_rnd = mant_sum[MantBits:1];
      exp_rnd  = side_b.exp + 1;
    end else begin
      mant_rnd = mant_sum[MantBits-1:0];
      exp_rnd  = side_b.exp;
    end
    // Subnormal that rounds up into the hidden bit becomes the smallest normal
    if (exp_rnd == 0) begin
      exp_field = {{(ExpBits-1){1'b0}}, mant_rnd[MantBits-1]};
    end else begin
      exp_field = exp_rnd[ExpBits-1:0];
    end
    overflow = (exp_rnd >= $signed(ExpExtBits'(ExpAllOnes)));
    // Modes rounding toward zero for this sign saturate at the largest finite value
    to_max   = (side_b.rm == RTZ) || (side_b.rm == RDN && !side_b.sign) ||
               (side_b.rm == RUP && side_b.sign);

    flags_d = '0;
    if (side_b.is_special) begin
      result_d   = side_b.special_result;
      flags_d.nv = side_b.special_invalid;
    end else if (zero_b) begin
      result_d = {side_b.sign, {(FpWidth-1){1'b0}}};
    end else if (overflow) begin
      result_d   = to_max ? {side_b.sign, ExpAllOnes - 1'b1, {FracBits{1'b1}}}
                          : {side_b.sign, ExpAllOnes, {FracBits{1'b0}}};
      flags_d.of = 1'b1;
      flags_d.nx = 1'b1;
    end else begin
      result_d   = {side_b.sign, exp_field, mant_rnd[FracBits-1:0]};
      flags_d.nx = inexact_b;
      // Tiny after rounding leaves a subnormal or zero exponent field
      flags_d.uf = inexact_b & (exp_field == '0);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= ld_b;
    end
  end

  always_ff @(posedge i_clk) begin
    o_result <= result_d;
    o_flags  <= flags_d;
  end

  // Strobe chain through all four stages must stay clean after reset
  a_valid_known: assert property (@(posedge i_clk) disable iff (i_rst)
    !$isunknown(o_valid));

endmodule

// ==== verilog/fp_mul_top.sv ====
// FMUL.S pipeline top: front end, multiplier, normalizer and rounder chained by stage links
module fp_mul_top
  import fp_mul_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_valid,
  input  logic [FpWidth-1:0] i_operand_a,
  input  logic [FpWidth-1:0] i_operand_b,
  input  logic [2:0]         i_rounding_mode,
  output logic               o_valid,
  output logic [FpWidth-1:0] o_result,
  output fp_flags_t          o_flags
);

  // ==================================================
  // Stage links
  // ==================================================

  // Front end to multiplier, carries both significands
  fp_stage_if #(.payload_t(mant_pair_t)) mul_if ();
  // Multiplier to normalizer, raw product
  fp_stage_if #(.payload_t(logic [ProdBits-1:0])) norm_if ();
  // Normalizer to rounder, product with leading one at the MSB
  fp_stage_if #(.payload_t(logic [ProdBits-1:0])) rnd_if ();

  // ==================================================
  // Stages, ten register edges from capture to o_valid
  // ==================================================

  // Two edges: operand capture, unpack and special cases
  fp_mul_front u_front (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_operand_a     (i_operand_a),
    .i_operand_b     (i_operand_b),
    .i_rounding_mode (rm_e'(i_rounding_mode)),
    .o_mul           (mul_if)
  );

  // Three edges: product register and delay line
  fp_mant_mul u_mant_mul (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_mul  (mul_if),
    .o_norm (norm_if)
  );

  // Two edges: leading-zero count, then shift
  fp_normalize u_normalize (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_norm (norm_if),
    .o_rnd  (rnd_if)
  );

  // Three edges: subnormal shift, round decision, packed output
  fp_round_pack u_round_pack (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_rnd    (rnd_if),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_flags  (o_flags)
  );

endmodule

// ==== sim/fp_mul_vectors.svh ====
// Directed FMUL.S vectors: test groups, operands, rounding modes, expected results and flags
`ifndef FP_MUL_VECTORS_SVH
`define FP_MUL_VECTORS_SVH

// Test groups
localparam int GrpExact   = 1;
localparam int GrpRound   = 2;
localparam int GrpSpecial = 3;
localparam int GrpRange   = 4;

localparam int NumVectors = 28;

// Columns: group, operand a, operand b, rounding mode, result, flags {nv, of, uf, nx}
task automatic load_vectors();
  // 1.5 x 2.0 and -3.0 x 0.5
  add_vector(GrpExact,   32'h3FC00000, 32'h40000000, 3'd0, 32'h40400000, 4'h0);
  add_vector(GrpExact,   32'hC0400000, 32'h3F000000, 3'd0, 32'hBFC00000, 4'h0);
  // 1.0000001 squared, just above 0x3F800002
  add_vector(GrpRound,   32'h3F800001, 32'h3F800001, 3'd0, 32'h3F800002, 4'h1);
  add_vector(GrpRound,   32'h3F800001, 32'h3F800001, 3'd1, 32'h3F800002, 4'h1);
  add_vector(GrpRound,   32'h3F800001, 32'h3F800001, 3'd2, 32'h3F800002, 4'h1);
  add_vector(GrpRound,   32'h3F800001, 32'h3F800001, 3'd3, 32'h3F800003, 4'h1);
  add_vector(GrpRound,   32'h3F800001, 32'h3F800001, 3'd4, 32'h3F800002, 4'h1);
  // Same magnitude with a negative sign, RDN and RUP swap roles
  add_vector(GrpRound,   32'hBF800001, 32'h3F800001, 3'd0, 32'hBF800002, 4'h1);
  add_vector(GrpRound,   32'hBF800001, 32'h3F800001, 3'd1, 32'hBF800002, 4'h1);
  add_vector(GrpRound,   32'hBF800001, 32'h3F800001, 3'd2, 32'hBF800003, 4'h1);
  add_vector(GrpRound,   32'hBF800001, 32'h3F800001, 3'd3, 32'hBF800002, 4'h1);
  add_vector(GrpRound,   32'hBF800001, 32'h3F800001, 3'd4, 32'hBF800002, 4'h1);
  // Exact tie between 0x3FC00004 and 0x3FC00005, even neighbour below
  add_vector(GrpRound,   32'h3F800003, 32'h3FC00000, 3'd0, 32'h3FC00004, 4'h1);
  add_vector(GrpRound,   32'h3F800003, 32'h3FC00000, 3'd1, 32'h3FC00004, 4'h1);
  add_vector(GrpRound,   32'h3F800003, 32'h3FC00000, 3'd2, 32'h3FC00004, 4'h1);
  add_vector(GrpRound,   32'h3F800003, 32'h3FC00000, 3'd3, 32'h3FC00005, 4'h1);
  add_vector(GrpRound,   32'h3F800003, 32'h3FC00000, 3'd4, 32'h3FC00005, 4'h1);
  // qNaN, sNaN, Inf x 0, -Inf x 2, -0 x 5
  add_vector(GrpSpecial, 32'h7FC00000, 32'h3F800000, 3'd0, 32'h7FC00000, 4'h0);
  add_vector(GrpSpecial, 32'h7F800001, 32'h3F800000, 3'd0, 32'h7FC00000, 4'h8);
  add_vector(GrpSpecial, 32'h7F800000, 32'h00000000, 3'd0, 32'h7FC00000, 4'h8);
  add_vector(GrpSpecial, 32'hFF800000, 32'h40000000, 3'd0, 32'hFF800000, 4'h0);
  add_vector(GrpSpecial, 32'h80000000, 32'h40A00000, 3'd0, 32'h80000000, 4'h0);
  // 2^127 x 2 overflows, to Inf under RNE and to the largest finite under RTZ
  add_vector(GrpRange,   32'h7F000000, 32'h40000000, 3'd0, 32'h7F800000, 4'h5);
  add_vector(GrpRange,   32'h7F000000, 32'h40000000, 3'd1, 32'h7F7FFFFF, 4'h5);
  // Subnormal inputs doubled, exact
  add_vector(GrpRange,   32'h00000001, 32'h40000000, 3'd0, 32'h00000002, 4'h0);
  add_vector(GrpRange,   32'h00200000, 32'h40000000, 3'd0, 32'h00400000, 4'h0);
  // 0.75 and 0.5 of the smallest subnormal, tiny and inexact
  add_vector(GrpRange,   32'h00000001, 32'h3F400000, 3'd0, 32'h00000001, 4'h3);
  add_vector(GrpRange,   32'h00000001, 32'h3F000000, 3'd0, 32'h00000000, 4'h3);
endtask

`endif

// ==== sim/fp_mul_tb.sv ====
// Testbench for the FMUL.S pipeline: clock, reset, directed vector tests, stream test, watchdog
module fp_mul_tb
  import fp_mul_pkg::*;
();

  // Register edges from i_valid capture to o_valid
  localparam int Latency   = 10;
  localparam int StreamLen = 20;

  logic        i_clk;
  logic        i_rst;
  logic        i_valid;
  logic [31:0] i_operand_a;
  logic [31:0] i_operand_b;
  logic [2:0]  i_rounding_mode;
  logic        o_valid;
  logic [31:0] o_result;
  fp_flags_t   o_flags;

  int     test_checks;
  int     test_errors;
  int     total_checks;
  int     total_errors;
  int     test_count;
  integer seed;

  // Vector table, one entry per column
  int          vec_group  [$];
  logic [31:0] vec_a      [$];
  logic [31:0] vec_b      [$];
  logic [2:0]  vec_rm     [$];
  logic [31:0] vec_result [$];
  fp_flags_t   vec_flags  [$];

  fp_mul_top u_dut (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_operand_a     (i_operand_a),
    .i_operand_b     (i_operand_b),
    .i_rounding_mode (i_rounding_mode),
    .o_valid         (o_valid),
    .o_result        (o_result),
    .o_flags         (o_flags)
  );

  initial begin
    i_clk = 1'b0;
  end

  // Period of 4
  always #2 i_clk = ~i_clk;

  task automatic add_vector(input int grp, input logic [31:0] a, input logic [31:0] b,
                            input logic [2:0] rm, input logic [31:0] result,
                            input fp_flags_t flags);
    vec_group.push_back(grp);
    vec_a.push_back(a);
    vec_b.push_back(b);
    vec_rm.push_back(rm);
    vec_result.push_back(result);
    vec_flags.push_back(flags);
  endtask

  `include "fp_mul_vectors.svh"

  // Exact binary32 encoding of (-1)^sign * mag * 2^pow2, mag below 2^24
  function automatic logic [31:0] make_float(input logic sign, input int mag, input int pow2);
    int          top;
    logic [31:0] aligned;
    top = 0;
    for (int i = 0; i < 24; i++) begin
      if (mag[i]) begin
        top = i;
      end
    end
    // Leading one lands on the hidden bit
    aligned = 32'(mag) << (23 - top);
    return {sign, 8'(127 + top + pow2), aligned[22:0]};
  endfunction

  // Per-test summary line, folds counts into the totals
  task automatic close_test(input string name);
    $display("%-16s checks %0d, errors %0d", name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    test_count++;
    test_checks = 0;
    test_errors = 0;
  endtask

  // ==================================================
  // Single operation, called on a falling edge
  // ==================================================

  task automatic issue_and_check(input logic [31:0] a, input logic [31:0] b,
                                 input logic [2:0] rm, input logic [31:0] exp_result,
                                 input fp_flags_t exp_flags);
    int cycle;
    i_valid         = 1'b1;
    i_operand_a     = a;
    i_operand_b     = b;
    i_rounding_mode = rm;
    @(negedge i_clk);
    i_valid = 1'b0;
    // Quiet until the tenth edge
    for (cycle = 1; cycle < Latency; cycle++) begin
      test_checks++;
      if (o_valid !== 1'b0) begin
        $display("Unexpected o_valid %0d cycles after issue of a=%08h b=%08h", cycle, a, b);
        test_errors++;
      end
      @(negedge i_clk);
    end
    test_checks += 3;
    if (o_valid !== 1'b1) begin
      $display("Missing o_valid %0d cycles after issue of a=%08h b=%08h", Latency, a, b);
      test_errors++;
    end
    if (o_result !== exp_result) begin
      $display("[FAIL] o_result: expected 0x%08h, got 0x%08h (a=%08h b=%08h rm=%0d)",
               exp_result, o_result, a, b, rm);
      test_errors++;
    end
    if (o_flags !== exp_flags) begin
      $display("[FAIL] o_flags: expected 0x%h, got 0x%h (a=%08h b=%08h rm=%0d)",
               exp_flags, o_flags, a, b, rm);
      test_errors++;
    end
    // Strobe lasts a single cycle
    @(negedge i_clk);
    test_checks++;
    if (o_valid !== 1'b0) begin
      $display("o_valid held for more than one cycle for a=%08h b=%08h", a, b);
      test_errors++;
    end
  endtask

  // ==================================================
  // Tests
  // ==================================================

  task automatic check_reset_idle();
    i_rst = 1'b1;
    for (int i = 0; i < 24; i++) begin
      @(negedge i_clk);
      test_checks++;
      if (o_valid !== 1'b0) begin
        $display("o_valid not low %0d cycles into the run with i_valid low", i + 1);
        test_errors++;
      end
      // Sixteen rising edges under reset
      if (i == 15) begin
        i_rst = 1'b0;
      end
    end
    close_test("reset_idle");
  endtask

  task automatic apply_vector_group(input int grp, input string name);
    for (int i = 0; i < vec_a.size(); i++) begin
      if (vec_group[i] == grp) begin
        issue_and_check(vec_a[i], vec_b[i], vec_rm[i], vec_result[i], vec_flags[i]);
      end
    end
    close_test(name);
  endtask

  // One issue per cycle, results checked in issue order
  task automatic stream_back_to_back();
    logic [31:0] stream_a   [StreamLen];
    logic [31:0] stream_b   [StreamLen];
    logic [2:0]  stream_rm  [StreamLen];
    logic [31:0] stream_exp [StreamLen];
    logic [31:0] rnd;
    int          mag_a;
    int          mag_b;
    int          pow_a;
    int          idx;
    // Small integer times a power of two, by a small integer, always exact
    for (int i = 0; i < StreamLen; i++) begin
      rnd           = $random(seed);
      mag_a         = (rnd[3:0] == 4'd0) ? 1 : int'(rnd[3:0]);
      mag_b         = (rnd[7:4] == 4'd0) ? 1 : int'(rnd[7:4]);
      pow_a         = int'(rnd[11:8]) - 8;
      stream_a[i]   = make_float(rnd[12], mag_a, pow_a);
      stream_b[i]   = make_float(rnd[13], mag_b, 0);
      stream_rm[i]  = (rnd[16:14] > 3'd4) ? 3'd0 : rnd[16:14];
      stream_exp[i] = make_float(rnd[12] ^ rnd[13], mag_a * mag_b, pow_a);
    end
    for (int t = 0; t <= StreamLen + Latency; t++) begin
      // Sample before driving, operation t - Latency is due now
      if (t >= Latency && t < StreamLen + Latency) begin
        idx = t - Latency;
        test_checks += 3;
        if (o_valid !== 1'b1) begin
          $display("Missing o_valid for stream operation %0d", idx);
          test_errors++;
        end
        if (o_result !== stream_exp[idx]) begin
          $display("[FAIL] o_result: expected 0x%08h, got 0x%08h (stream op %0d)",
                   stream_exp[idx], o_result, idx);
          test_errors++;
        end
        if (o_flags !== 4'h0) begin
          $display("[FAIL] o_flags: expected 0x0, got 0x%h (stream op %0d)", o_flags, idx);
          test_errors++;
        end
      end else begin
        test_checks++;
        if (o_valid !== 1'b0) begin
          $display("Unexpected o_valid at stream cycle %0d", t);
          test_errors++;
        end
      end
      if (t < StreamLen) begin
        i_valid         = 1'b1;
        i_operand_a     = stream_a[t];
        i_operand_b     = stream_b[t];
        i_rounding_mode = stream_rm[t];
      end else begin
        i_valid = 1'b0;
      end
      @(negedge i_clk);
    end
    close_test("back_to_back");
  endtask

  // ==================================================
  // Sequence and summary
  // ==================================================

  initial begin
    seed            = 32'he7d4;
    test_checks     = 0;
    test_errors     = 0;
    total_checks    = 0;
    total_errors    = 0;
    test_count      = 0;
    i_rst           = 1'b1;
    i_valid         = 1'b0;
    i_operand_a     = '0;
    i_operand_b     = '0;
    i_rounding_mode = 3'd0;
    load_vectors();
    if (vec_a.size() != NumVectors) begin
      $display("Vector table holds %0d entries instead of %0d", vec_a.size(), NumVectors);
      total_errors++;
    end
    check_reset_idle();
    apply_vector_group(GrpExact, "exact_products");
    apply_vector_group(GrpRound, "rounding_modes");
    apply_vector_group(GrpSpecial, "special_cases");
    apply_vector_group(GrpRange, "range_limits");
    stream_back_to_back();
    $display("Tests %0d, checks %0d, errors %0d", test_count, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Roughly twelve cycles per operation with margin
  initial begin
    repeat ((NumVectors + StreamLen) * 12) @(posedge i_clk);
    $display("Timeout, tests still running after %0d cycles", (NumVectors + StreamLen) * 12);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+sim
verilog/fp_mul_pkg.sv
verilog/fp_stage_if.sv
verilog/fp_operand_unpack.sv
verilog/fp_mul_front.sv
verilog/fp_mant_mul.sv
verilog/fp_normalize.sv
verilog/fp_round_pack.sv
verilog/fp_mul_top.sv
sim/fp_mul_tb.sv
